// File: design/alu_fu.sv
`timescale 1ns/10ps

module alu_fu
	import core_pkg::*;
(
	input					clk,
	input					rst_i,
	input					iss_vld_i,
	input	[63:0]			opa_val_i,
	input	[63:0]			opb_val_i,
	input	[7:0]			lit_i,
	input					use_lit_i,
	input	alu_op_e		op_i,
	input	preg_t			dest_tag_i,
	input					dest_zero_i,
	input	rob_idx_t		rob_idx_i,
	output	logic			cdb_vld_o,
	output	preg_t			cdb_tag_o,
	output	logic	[63:0]	cdb_val_o,
	output	logic			cdb_wr_o,
	output	rob_idx_t		cdb_rob_idx_o
);

	logic	[63:0]	opb;
	logic	[63:0]	res;

	assign opb = use_lit_i ? {56'h0, lit_i} : opb_val_i;	// literal zero-extended

	always_comb begin
		case (op_i)
			ADD:		res = opa_val_i + opb;
			SUB:		res = opa_val_i - opb;
			CMPEQ:		res = {63'h0, (opa_val_i == opb)};
			AND:		res = opa_val_i & opb;
			OR:			res = opa_val_i | opb;
			XOR:		res = opa_val_i ^ opb;
			default:	res = 64'h0;
		endcase
	end

	// one cycle to the cdb
	always_ff @(posedge clk) begin
		if (rst_i) begin
			cdb_vld_o <= 1'b0;
			cdb_wr_o  <= 1'b0;
		end else begin
			cdb_vld_o <= iss_vld_i;
			cdb_wr_o  <= iss_vld_i && !dest_zero_i;		// r31 dest, no prf write
		end
	end

	always_ff @(posedge clk) begin
		cdb_tag_o     <= dest_tag_i;
		cdb_val_o     <= res;
		cdb_rob_idx_o <= rob_idx_i;
	end

endmodule

// File: design/core.sv
`timescale 1ns/10ps
`include "core_config.svh"

module core
	import isa_pkg::*;
	import core_pkg::*;
(
	input					clk,
	input					rst_i,
	input					inst_vld_i,
	input	inst_u			inst_i,
	output	logic			inst_rdy_o,
	output	logic			retire_vld_o,
	output	areg_t			retire_areg_o,
	output	logic	[63:0]	retire_val_o,
	output	status_e		core_status_o
);

	// dispatch
	logic			disp_en, opb_lit, to_rs, halt, illegal;
	areg_t			ra, rb, rc;
	logic	[7:0]	lit;
	alu_op_e		alu_op;
	// rename
	logic			free_vld, opa_rdy, opb_rdy;
	preg_t			free_tag, opa_tag, opb_tag, old_tag;
	// rob
	rob_idx_t		rob_tail;
	logic			rob_full, retire_zero, fl_push;
	preg_t			retire_tag, fl_tag, rdr_idx;
	// issue
	logic			rs_full, iss_vld, iss_use_lit, iss_dest_zero;
	preg_t			iss_opa_tag, iss_opb_tag, iss_dest_tag;
	logic	[7:0]	iss_lit;
	alu_op_e		iss_op;
	rob_idx_t		iss_rob_idx;
	logic	[63:0]	opa_val, opb_val;
	// cdb
	logic			cdb_vld, cdb_wr;
	preg_t			cdb_tag;
	logic	[63:0]	cdb_val;
	rob_idx_t		cdb_rob_idx;

	// r31 retires through tag 31, which reads zero
	assign rdr_idx = retire_zero ? preg_t'(`ZERO_REG) : retire_tag;

	// ==================================================
	dispatch dispatch_i (
		.clk			(clk),			.rst_i			(rst_i),
		.inst_vld_i		(inst_vld_i),	.inst_i			(inst_i),
		.rob_full_i		(rob_full),		.rs_full_i		(rs_full),
		.free_vld_i		(free_vld),		.inst_rdy_o		(inst_rdy_o),
		.disp_en_o		(disp_en),		.ra_o			(ra),
		.rb_o			(rb),			.rc_o			(rc),
		.opb_lit_o		(opb_lit),		.lit_o			(lit),
		.alu_op_o		(alu_op),		.to_rs_o		(to_rs),
		.halt_o			(halt),			.illegal_o		(illegal)
	);

	// ready bits and rs wakeup follow cdb_wr; an r31 result carries a tag never popped
	map_table map_table_i (
		.clk			(clk),			.rst_i			(rst_i),
		.disp_en_i		(disp_en),		.ra_i			(ra),
		.rb_i			(rb),			.rc_i			(rc),
		.new_tag_i		(free_tag),		.cdb_vld_i		(cdb_wr),
		.cdb_tag_i		(cdb_tag),		.opa_tag_o		(opa_tag),
		.opb_tag_o		(opb_tag),		.opa_rdy_o		(opa_rdy),
		.opb_rdy_o		(opb_rdy),		.old_tag_o		(old_tag)
	);

	free_list free_list_i (
		.clk			(clk),			.rst_i			(rst_i),
		.pop_i			(disp_en && (rc != `ZERO_REG)),
		.push_i			(fl_push),		.push_tag_i		(fl_tag),
		.free_vld_o		(free_vld),		.free_tag_o		(free_tag)
	);

	rob rob_i (
		.clk			(clk),			.rst_i			(rst_i),
		.disp_en_i		(disp_en),		.rc_i			(rc),
		.new_tag_i		(free_tag),		.old_tag_i		(old_tag),
		.done_at_disp_i	(!to_rs),		.halt_i			(halt),
		.illegal_i		(illegal),		.cdb_vld_i		(cdb_vld),
		.cdb_rob_idx_i	(cdb_rob_idx),	.tail_o			(rob_tail),
		.rob_full_o		(rob_full),		.retire_vld_o	(retire_vld_o),
		.retire_areg_o	(retire_areg_o),	.retire_tag_o	(retire_tag),
		.retire_zero_o	(retire_zero),	.fl_push_o		(fl_push),
		.fl_tag_o		(fl_tag),		.status_o		(core_status_o)
	);

	rs rs_i (
		.clk			(clk),			.rst_i			(rst_i),
		.disp_en_i		(disp_en),		.to_rs_i		(to_rs),
		.opa_tag_i		(opa_tag),		.opb_tag_i		(opb_tag),
		.opa_rdy_i		(opa_rdy),		.opb_rdy_i		(opb_rdy),
		.opb_lit_i		(opb_lit),		.lit_i			(lit),
		.dest_tag_i		(free_tag),		.dest_zero_i	(rc == `ZERO_REG),
		.alu_op_i		(alu_op),		.rob_idx_i		(rob_tail),
		.cdb_vld_i		(cdb_wr),		.cdb_tag_i		(cdb_tag),
		.rs_full_o		(rs_full),		.iss_vld_o		(iss_vld),
		.iss_opa_tag_o	(iss_opa_tag),	.iss_opb_tag_o	(iss_opb_tag),
		.iss_lit_o		(iss_lit),		.iss_use_lit_o	(iss_use_lit),
		.iss_op_o		(iss_op),		.iss_dest_tag_o	(iss_dest_tag),
		.iss_dest_zero_o	(iss_dest_zero),	.iss_rob_idx_o	(iss_rob_idx)
	);

	alu_fu alu_fu_i (
		.clk			(clk),			.rst_i			(rst_i),
		.iss_vld_i		(iss_vld),		.opa_val_i		(opa_val),
		.opb_val_i		(opb_val),		.lit_i			(iss_lit),
		.use_lit_i		(iss_use_lit),	.op_i			(iss_op),
		.dest_tag_i		(iss_dest_tag),	.dest_zero_i	(iss_dest_zero),
		.rob_idx_i		(iss_rob_idx),	.cdb_vld_o		(cdb_vld),
		.cdb_tag_o		(cdb_tag),		.cdb_val_o		(cdb_val),
		.cdb_wr_o		(cdb_wr),		.cdb_rob_idx_o	(cdb_rob_idx)
	);

	preg_file preg_file_i (
		.clk			(clk),			.rst_i			(rst_i),
		.rda_idx_i		(iss_opa_tag),	.rdb_idx_i		(iss_opb_tag),
		.rdr_idx_i		(rdr_idx),		.wr_en_i		(cdb_wr),
		.wr_idx_i		(cdb_tag),		.wr_data_i		(cdb_val),
		.rda_data_o		(opa_val),		.rdb_data_o		(opb_val),
		.rdr_data_o		(retire_val_o)
	);

endmodule

// File: design/core_config.svh
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// ==================================================
// register files
`define AREG_NUM	32
`define ZERO_REG	5'd31		// hard zero, never renamed
`define PRF_NUM		64
`define PRF_IDX_W	6

// window sizes
`define ROB_NUM		16
`define ROB_IDX_W	4
`define RS_NUM		4

// ==================================================
// opcodes and function codes
`define OP_INTA		6'h10		// integer arithmetic
`define OP_INTL		6'h11		// integer logic
`define OP_PAL		6'h00		// call_pal, only halt kept

`define F_ADDQ		7'h20
`define F_SUBQ		7'h29
`define F_CMPEQ		7'h2d
`define F_AND		7'h00
`define F_BIS		7'h20		// alpha name for or
`define F_XOR		7'h40

// status codes
`define ST_NO_ERROR	4'h0
`define ST_HALT		4'h2
`define ST_ILLEGAL	4'h3

`endif

// File: design/core_pkg.sv
`include "core_config.svh"

package core_pkg;

	typedef logic [`PRF_IDX_W-1:0] preg_t;		// physical tag
	typedef logic [`ROB_IDX_W-1:0] rob_idx_t;	// rob slot

	// alu operation, encoded at dispatch
	typedef enum logic [2:0] {
		ADD		= 3'd0,
		SUB		= 3'd1,
		CMPEQ	= 3'd2,
		AND		= 3'd3,
		OR		= 3'd4,
		XOR		= 3'd5
	} alu_op_e;

endpackage

// File: design/dispatch.sv
`timescale 1ns/10ps
`include "core_config.svh"

module dispatch
	import isa_pkg::*;
	import core_pkg::*;
(
	input					clk,
	input					rst_i,
	input					inst_vld_i,
	input	inst_u			inst_i,
	input					rob_full_i,
	input					rs_full_i,
	input					free_vld_i,
	output	logic			inst_rdy_o,
	output	logic			disp_en_o,
	output	areg_t			ra_o,
	output	areg_t			rb_o,
	output	areg_t			rc_o,
	output	logic			opb_lit_o,
	output	logic	[7:0]	lit_o,
	output	alu_op_e		alu_op_o,
	output	logic			to_rs_o,
	output	logic			halt_o,
	output	logic			illegal_o
);

	logic	stop_q;		// sticky once a halt or illegal is taken

	// ==================================================
	// decode
	always_comb begin
		alu_op_o  = ADD;
		halt_o    = 1'b0;
		illegal_o = 1'b0;
		case (inst_i.r.opcode)
			`OP_INTA: begin
				case (inst_i.r.func)
					`F_ADDQ:	alu_op_o = ADD;
					`F_SUBQ:	alu_op_o = SUB;
					`F_CMPEQ:	alu_op_o = CMPEQ;
					default:	illegal_o = 1'b1;
				endcase
			end
			`OP_INTL: begin
				case (inst_i.r.func)
					`F_AND:		alu_op_o = AND;
					`F_BIS:		alu_op_o = OR;
					`F_XOR:		alu_op_o = XOR;
					default:	illegal_o = 1'b1;
				endcase
			end
			`OP_PAL: begin
				halt_o    = (inst_i[25:0] == 26'h0);	// pal function 0 is halt
				illegal_o = !halt_o;
			end
			default:	illegal_o = 1'b1;
		endcase
	end

	assign to_rs_o   = !(halt_o || illegal_o);
	assign opb_lit_o = inst_i.r.is_lit;
	assign lit_o     = inst_i.l.lit;		// only meaningful in literal form
	assign ra_o      = inst_i.r.ra;
	// literal form points b at r31, which is always ready
	assign rb_o      = inst_i.r.is_lit ? `ZERO_REG : inst_i.r.rb;
	assign rc_o      = to_rs_o ? inst_i.r.rc : `ZERO_REG;	// halt/illegal renames nothing

	// free-list term applies to every word including an r31 dest
	assign inst_rdy_o = !stop_q && !rob_full_i && !rs_full_i && free_vld_i;
	assign disp_en_o  = inst_vld_i && inst_rdy_o;

	always_ff @(posedge clk) begin
		if (rst_i)
			stop_q <= 1'b0;
		else if (disp_en_o && !to_rs_o)
			stop_q <= 1'b1;
	end

	// a stalled word stays put until it is taken
	a_hold_word: assert property (@(posedge clk) disable iff (rst_i)
		(inst_vld_i && !inst_rdy_o) |=> $stable(inst_i));

endmodule

// File: design/free_list.sv
`timescale 1ns/10ps
`include "core_config.svh"

module free_list
	import core_pkg::*;
(
	input					clk,
	input					rst_i,
	input					pop_i,
	input					push_i,
	input	preg_t			push_tag_i,
	output	logic			free_vld_o,
	output	preg_t			free_tag_o
);

	localparam int FL_NUM   = `PRF_NUM - `AREG_NUM;	// tags not held by the arch state
	localparam int FL_PTR_W = $clog2(FL_NUM);

	preg_t					q [FL_NUM];
	logic	[FL_PTR_W-1:0]	head_q;
	logic	[FL_PTR_W-1:0]	tail_q;
	logic	[FL_PTR_W:0]	cnt_q;

	assign free_vld_o = (cnt_q != '0);
	assign free_tag_o = q[head_q];

	always_ff @(posedge clk) begin
		if (rst_i) begin
			for (int i = 0; i < FL_NUM; i++)
				q[i] <= preg_t'(`AREG_NUM + i);		// tags 32..63 start free
			head_q <= '0;
			tail_q <= '0;
			cnt_q  <= (FL_PTR_W+1)'(FL_NUM);
		end else begin
			if (pop_i)
				head_q <= head_q + 1'b1;
			if (push_i) begin
				q[tail_q] <= push_tag_i;	// old tag back from retire
				tail_q    <= tail_q + 1'b1;
			end
			cnt_q <= cnt_q + (FL_PTR_W+1)'(push_i) - (FL_PTR_W+1)'(pop_i);
		end
	end

	// dispatch only pops what is there
	a_pop_empty: assert property (@(posedge clk) disable iff (rst_i)
		pop_i |-> free_vld_o);

	// retire never hands back more tags than exist
	a_push_full: assert property (@(posedge clk) disable iff (rst_i)
		push_i |-> (cnt_q < FL_NUM));

endmodule

// File: design/isa_pkg.sv
`include "core_config.svh"

package isa_pkg;

	typedef logic [$clog2(`AREG_NUM)-1:0] areg_t;	// architectural register index

	// operate format, register form
	typedef struct packed {
		logic	[5:0]	opcode;
		areg_t			ra;
		areg_t			rb;
		logic	[2:0]	sbz;		// should be zero
		logic			is_lit;		// bit 12, low here
		logic	[6:0]	func;
		areg_t			rc;
	} op_reg_t;

	// operate format, literal form
	// 8 bits of literal sit where rb and sbz were
	typedef struct packed {
		logic	[5:0]	opcode;
		areg_t			ra;
		logic	[7:0]	lit;
		logic			is_lit;		// bit 12, high here
		logic	[6:0]	func;
		areg_t			rc;
	} op_lit_t;

	// one word, two readings; is_lit picks the valid one
	typedef union packed {
		op_reg_t	r;
		op_lit_t	l;
	} inst_u;

	// core error status
	typedef enum logic [3:0] {
		NO_ERROR			= `ST_NO_ERROR,
		HALTED_ON_HALT		= `ST_HALT,
		HALTED_ON_ILLEGAL	= `ST_ILLEGAL
	} status_e;

endpackage

// File: design/map_table.sv
`timescale 1ns/10ps
`include "core_config.svh"

module map_table
	import isa_pkg::*;
	import core_pkg::*;
(
	input					clk,
	input					rst_i,
	input					disp_en_i,
	input	areg_t			ra_i,
	input	areg_t			rb_i,
	input	areg_t			rc_i,
	input	preg_t			new_tag_i,
	input					cdb_vld_i,
	input	preg_t			cdb_tag_i,
	output	preg_t			opa_tag_o,
	output	preg_t			opb_tag_o,
	output	logic			opa_rdy_o,
	output	logic			opb_rdy_o,
	output	preg_t			old_tag_o
);

	preg_t					map_q [`AREG_NUM];	// areg -> current tag
	logic	[`PRF_NUM-1:0]	rdy_q;				// value present in prf

	assign opa_tag_o = map_q[ra_i];
	assign opb_tag_o = map_q[rb_i];
	assign old_tag_o = map_q[rc_i];		// goes to rob, freed at retire

	// same-cycle cdb forwards into the ready bits
	assign opa_rdy_o = rdy_q[opa_tag_o] || (cdb_vld_i && (cdb_tag_i == opa_tag_o));
	assign opb_rdy_o = rdy_q[opb_tag_o] || (cdb_vld_i && (cdb_tag_i == opb_tag_o));

	always_ff @(posedge clk) begin
		if (rst_i) begin
			for (int i = 0; i < `AREG_NUM; i++)
				map_q[i] <= preg_t'(i);		// identity map
			rdy_q <= '1;
		end else begin
			if (cdb_vld_i)
				rdy_q[cdb_tag_i] <= 1'b1;
			// new tag is off the free list, never the cdb tag
			if (disp_en_i && (rc_i != `ZERO_REG)) begin
				map_q[rc_i]      <= new_tag_i;
				rdy_q[new_tag_i] <= 1'b0;
			end
		end
	end

endmodule

// File: design/preg_file.sv
`timescale 1ns/10ps
`include "core_config.svh"

module preg_file
	import core_pkg::*;
(
	input					clk,
	input					rst_i,
	input	preg_t			rda_idx_i,
	input	preg_t			rdb_idx_i,
	input	preg_t			rdr_idx_i,
	input					wr_en_i,
	input	preg_t			wr_idx_i,
	input	[63:0]			wr_data_i,
	output	logic	[63:0]	rda_data_o,
	output	logic	[63:0]	rdb_data_o,
	output	logic	[63:0]	rdr_data_o
);

	logic	[63:0]	regs_q [`PRF_NUM];

	assign rda_data_o = regs_q[rda_idx_i];
	assign rdb_data_o = regs_q[rdb_idx_i];
	assign rdr_data_o = regs_q[rdr_idx_i];		// retire port

	always_ff @(posedge clk) begin
		if (rst_i) begin
			for (int i = 0; i < `PRF_NUM; i++)
				regs_q[i] <= 64'h0;
		end else if (wr_en_i && (wr_idx_i != preg_t'(`ZERO_REG))) begin
			regs_q[wr_idx_i] <= wr_data_i;	// tag 31 holds r31, stays zero
		end
	end

endmodule

// File: design/rob.sv
`timescale 1ns/10ps
`include "core_config.svh"

module rob
	import isa_pkg::*;
	import core_pkg::*;
(
	input					clk,
	input					rst_i,
	input					disp_en_i,
	input	areg_t			rc_i,
	input	preg_t			new_tag_i,
	input	preg_t			old_tag_i,
	input					done_at_disp_i,
	input					halt_i,
	input					illegal_i,
	input					cdb_vld_i,
	input	rob_idx_t		cdb_rob_idx_i,
	output	rob_idx_t		tail_o,
	output	logic			rob_full_o,
	output	logic			retire_vld_o,
	output	areg_t			retire_areg_o,
	output	preg_t			retire_tag_o,
	output	logic			retire_zero_o,
	output	logic			fl_push_o,
	output	preg_t			fl_tag_o,
	output	status_e		status_o
);

	// entry payload, written at allocation
	areg_t					areg_q    [`ROB_NUM];
	preg_t					new_tag_q [`ROB_NUM];
	preg_t					old_tag_q [`ROB_NUM];
	logic	[`ROB_NUM-1:0]	halt_q;
	logic	[`ROB_NUM-1:0]	ill_q;

	logic	[`ROB_NUM-1:0]	done_q;
	rob_idx_t				head_q;
	rob_idx_t				tail_q;
	logic	[`ROB_IDX_W:0]	cnt_q;
	logic					head_go;	// head retires this cycle
	logic					head_stop;	// head is halt or illegal

	// retire only a done head, and nothing once stopped
	assign head_go   = (cnt_q != '0) && done_q[head_q] && (status_o == NO_ERROR);
	assign head_stop = halt_q[head_q] || ill_q[head_q];

	assign retire_vld_o  = head_go && !head_stop;
	assign retire_areg_o = areg_q[head_q];
	assign retire_tag_o  = new_tag_q[head_q];
	assign retire_zero_o = (areg_q[head_q] == `ZERO_REG);
	assign fl_push_o     = retire_vld_o && !retire_zero_o;	// r31 dest was never renamed
	assign fl_tag_o      = old_tag_q[head_q];

	assign tail_o     = tail_q;
	assign rob_full_o = cnt_q[`ROB_IDX_W];		// count reached ROB_NUM

	always_ff @(posedge clk) begin
		if (rst_i) begin
			head_q   <= '0;
			tail_q   <= '0;
			cnt_q    <= '0;
			done_q   <= '0;
			status_o <= NO_ERROR;
		end else begin
			if (cdb_vld_i)
				done_q[cdb_rob_idx_i] <= 1'b1;
			if (disp_en_i) begin
				done_q[tail_q] <= done_at_disp_i;	// halt/illegal arrive done
				tail_q         <= tail_q + 1'b1;
			end
			if (head_go) begin
				head_q <= head_q + 1'b1;
				if (halt_q[head_q])
					status_o <= HALTED_ON_HALT;
				else if (ill_q[head_q])
					status_o <= HALTED_ON_ILLEGAL;
			end
			cnt_q <= cnt_q + (`ROB_IDX_W+1)'(disp_en_i) - (`ROB_IDX_W+1)'(head_go);
		end
	end

	always_ff @(posedge clk) begin
		if (disp_en_i) begin
			areg_q[tail_q]    <= rc_i;
			new_tag_q[tail_q] <= new_tag_i;
			old_tag_q[tail_q] <= old_tag_i;
			halt_q[tail_q]    <= halt_i;
			ill_q[tail_q]     <= illegal_i;
		end
	end

	// each entry completes exactly once, from the alu
	a_cdb_once: assert property (@(posedge clk) disable iff (rst_i)
		cdb_vld_i |-> !done_q[cdb_rob_idx_i]);

endmodule

// File: design/rs.sv
`timescale 1ns/10ps
`include "core_config.svh"

module rs
	import core_pkg::*;
(
	input					clk,
	input					rst_i,
	input					disp_en_i,
	input					to_rs_i,
	input	preg_t			opa_tag_i,
	input	preg_t			opb_tag_i,
	input					opa_rdy_i,
	input					opb_rdy_i,
	input					opb_lit_i,
	input	[7:0]			lit_i,
	input	preg_t			dest_tag_i,
	input					dest_zero_i,
	input	alu_op_e		alu_op_i,
	input	rob_idx_t		rob_idx_i,
	input					cdb_vld_i,
	input	preg_t			cdb_tag_i,
	output	logic			rs_full_o,
	output	logic			iss_vld_o,
	output	preg_t			iss_opa_tag_o,
	output	preg_t			iss_opb_tag_o,
	output	logic	[7:0]	iss_lit_o,
	output	logic			iss_use_lit_o,
	output	alu_op_e		iss_op_o,
	output	preg_t			iss_dest_tag_o,
	output	logic			iss_dest_zero_o,
	output	rob_idx_t		iss_rob_idx_o
);

	// age counts younger entries still held, so it never passes RS_NUM-1
	localparam int IDX_W = $clog2(`RS_NUM);

	logic	[`RS_NUM-1:0]	vld_q;
	logic	[`RS_NUM-1:0]	ra_q;		// operand a ready
	logic	[`RS_NUM-1:0]	rb_q;		// operand b ready
	preg_t					ta_q [`RS_NUM];
	preg_t					tb_q [`RS_NUM];
	preg_t					td_q [`RS_NUM];
	logic	[7:0]			lit_q [`RS_NUM];
	logic	[`RS_NUM-1:0]	use_lit_q;
	logic	[`RS_NUM-1:0]	dz_q;
	alu_op_e				op_q [`RS_NUM];
	rob_idx_t				rob_q [`RS_NUM];
	logic	[IDX_W-1:0]		age_q [`RS_NUM];

	logic	[`RS_NUM-1:0]	rdy;
	logic					any_rdy;
	logic	[IDX_W-1:0]		sel_idx;
	logic	[IDX_W-1:0]		free_idx;
	logic					ins;		// new entry this cycle

	assign rdy       = vld_q & ra_q & rb_q;
	assign rs_full_o = &vld_q;
	assign ins       = disp_en_i && to_rs_i;

	// ==================================================
	// pick oldest ready
	always_comb begin
		any_rdy = 1'b0;
		sel_idx = '0;
		for (int i = 0; i < `RS_NUM; i++) begin
			if (rdy[i] && (!any_rdy || (age_q[i] > age_q[sel_idx]))) begin
				any_rdy = 1'b1;
				sel_idx = IDX_W'(i);
			end
		end
	end

	// lowest empty slot
	always_comb begin
		free_idx = '0;
		for (int i = `RS_NUM-1; i >= 0; i--) begin
			if (!vld_q[i])
				free_idx = IDX_W'(i);
		end
	end

	assign iss_vld_o       = any_rdy;
	assign iss_opa_tag_o   = ta_q[sel_idx];
	assign iss_opb_tag_o   = tb_q[sel_idx];
	assign iss_lit_o       = lit_q[sel_idx];
	assign iss_use_lit_o   = use_lit_q[sel_idx];
	assign iss_op_o        = op_q[sel_idx];
	assign iss_dest_tag_o  = td_q[sel_idx];
	assign iss_dest_zero_o = dz_q[sel_idx];
	assign iss_rob_idx_o   = rob_q[sel_idx];

	// ==================================================
	always_ff @(posedge clk) begin
		if (rst_i) begin
			vld_q <= '0;
		end else begin
			if (any_rdy)
				vld_q[sel_idx] <= 1'b0;		// freed on issue
			if (ins)
				vld_q[free_idx] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < `RS_NUM; i++) begin
			// wakeup
			if (cdb_vld_i && (ta_q[i] == cdb_tag_i))
				ra_q[i] <= 1'b1;
			if (cdb_vld_i && (tb_q[i] == cdb_tag_i))
				rb_q[i] <= 1'b1;
			// +1 for a newcomer, -1 when a younger one leaves
			age_q[i] <= age_q[i] + IDX_W'(ins)
				- IDX_W'(any_rdy && (age_q[i] > age_q[sel_idx]));
		end
		if (ins) begin
			ta_q[free_idx]      <= opa_tag_i;
			tb_q[free_idx]      <= opb_tag_i;
			ra_q[free_idx]      <= opa_rdy_i;
			rb_q[free_idx]      <= opb_rdy_i;
			td_q[free_idx]      <= dest_tag_i;
			dz_q[free_idx]      <= dest_zero_i;
			lit_q[free_idx]     <= lit_i;
			use_lit_q[free_idx] <= opb_lit_i;
			op_q[free_idx]      <= alu_op_i;
			rob_q[free_idx]     <= rob_idx_i;
			age_q[free_idx]     <= '0;		// youngest
		end
	end

endmodule

// File: sim.f
+incdir+design
+incdir+test
design/isa_pkg.sv
design/core_pkg.sv
design/dispatch.sv
design/map_table.sv
design/free_list.sv
design/rob.sv
design/rs.sv
design/alu_fu.sv
design/preg_file.sv
design/core.sv
test/core_tb.sv

// File: test/core_tb_check.svh
`ifndef CORE_TB_CHECK_SVH
`define CORE_TB_CHECK_SVH

// ==================================================
// reference model, architectural level only

typedef enum {K_OP, K_HALT, K_ILLEGAL} kind_e;

logic	[63:0]	arch_q [`AREG_NUM];		// r31 is never written, stays zero
areg_t			exp_areg_q [$];			// expected retire order
logic	[63:0]	exp_val_q [$];

// accepted words: inta add/sub/cmpeq, intl and/bis/xor, pal 0
function automatic kind_e word_kind(inst_u w);
	kind_e	k;
	k = K_ILLEGAL;
	case (w.r.opcode)
		`OP_INTA:	if (w.r.func inside {`F_ADDQ, `F_SUBQ, `F_CMPEQ}) k = K_OP;
		`OP_INTL:	if (w.r.func inside {`F_AND, `F_BIS, `F_XOR}) k = K_OP;
		`OP_PAL:	if (w[25:0] == 26'h0) k = K_HALT;
		default:	k = K_ILLEGAL;
	endcase
	return k;
endfunction

function automatic logic [63:0] word_result(inst_u w);
	logic	[63:0]	a;
	logic	[63:0]	b;
	logic	[63:0]	res;
	a = arch_q[w.r.ra];
	b = w.r.is_lit ? {56'h0, w.l.lit} : arch_q[w.r.rb];	// literal is zero-extended
	if (w.r.opcode == `OP_INTA) begin
		case (w.r.func)
			`F_ADDQ:	res = a + b;
			`F_SUBQ:	res = a - b;
			default:	res = {63'h0, (a == b)};	// cmpeq
		endcase
	end else begin
		case (w.r.func)
			`F_AND:		res = a & b;
			`F_BIS:		res = a | b;
			default:	res = a ^ b;
		endcase
	end
	return res;
endfunction

// program order, one call per accepted word
task automatic model_accept(inst_u w);
	logic	[63:0]	res;
	if (word_kind(w) == K_OP) begin
		res = word_result(w);
		if (w.r.rc != `ZERO_REG)
			arch_q[w.r.rc] = res;
		exp_areg_q.push_back(w.r.rc);
		exp_val_q.push_back((w.r.rc == `ZERO_REG) ? 64'h0 : res);	// r31 retires as zero
	end
endtask

task automatic model_reset();
	for (int i = 0; i < `AREG_NUM; i++)
		arch_q[i] = 64'h0;		// prf cleared, identity map
	exp_areg_q.delete();
	exp_val_q.delete();
endtask

// ==================================================
// compare tasks

task automatic check_retire(areg_t got_areg, logic [63:0] got_val);
	areg_t			exp_areg;
	logic	[63:0]	exp_val;
	if (exp_areg_q.size() == 0) begin
		$display("retirement of r%0d at %0t with no instruction outstanding", got_areg, $time);
		$display("test failed");
		$fatal(1, "extra retirement");
	end else begin
		exp_areg = exp_areg_q.pop_front();
		exp_val  = exp_val_q.pop_front();
		if ((got_areg !== exp_areg) || (got_val !== exp_val)) begin
			$display("ERR %0t: retired r%0d = %h, expected r%0d = %h",
				$time, got_areg, got_val, exp_areg, exp_val);
			$display("test failed");
			$fatal(1, "retire mismatch");
		end
	end
endtask

task automatic check_status(status_e got, status_e exp);
	if (got !== exp) begin
		$display("ERR %0t: core status %0h, expected %0h", $time, got, exp);
		$display("test failed");
		$fatal(1, "status mismatch");
	end
endtask

task automatic check_rdy(logic got, logic exp);
	if (got !== exp) begin
		$display("ERR %0t: inst_rdy_o %b, expected %b", $time, got, exp);
		$display("test failed");
		$fatal(1, "ready mismatch");
	end
endtask

// everything older than the stop word must be gone
task automatic check_drained();
	if (exp_areg_q.size() != 0) begin
		$display("core stopped at %0t with %0d instructions never retired",
			$time, exp_areg_q.size());
		$display("test failed");
		$fatal(1, "missing retirements");
	end
endtask

`endif

// File: test/core_tb.sv
`timescale 1ns/10ps
`include "core_config.svh"

module core_tb
	import isa_pkg::*;
();

	localparam int			CLK_PERIOD  = 100;
	localparam int			RST_CYCLES  = 10;
	localparam int			N_INST      = 400;		// last one is the halt
	localparam int			CHAIN_START = 60;
	localparam int			CHAIN_LEN   = 24;		// longer than the rob
	localparam areg_t		CHAIN_REG   = 5'd7;
	localparam int			ILL_IDX     = 200;		// at least one illegal
	localparam int			WD_CYCLES   = N_INST * 40 + RST_CYCLES;
	localparam logic [31:0]	SEED        = 32'hf368ddf0;

	logic			clk = 1'b0;
	logic			rst_i;
	logic			inst_vld_i;
	inst_u			inst_i;
	logic			inst_rdy_o;
	logic			retire_vld_o;
	areg_t			retire_areg_o;
	logic	[63:0]	retire_val_o;
	status_e		core_status_o;

	logic	[31:0]	lcg_state = SEED;

	`include "core_tb_check.svh"

	always #(CLK_PERIOD / 2) clk = ~clk;

	core core_i (
		.clk			(clk),
		.rst_i			(rst_i),
		.inst_vld_i		(inst_vld_i),
		.inst_i			(inst_i),
		.inst_rdy_o		(inst_rdy_o),
		.retire_vld_o	(retire_vld_o),
		.retire_areg_o	(retire_areg_o),
		.retire_val_o	(retire_val_o),
		.core_status_o	(core_status_o)
	);

	// ==================================================
	// random source
	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic int rand_below(int lim);
		logic	[31:0]	r;
		r = next_rand();
		return int'(r[31:16]) % lim;		// upper bits since the low ones cycle fast
	endfunction

	// r31 picked about one time in seven
	function automatic areg_t pick_reg();
		int	r;
		r = rand_below(36);
		return (r >= 31) ? `ZERO_REG : areg_t'(r);
	endfunction

	function automatic inst_u make_word(int n);
		inst_u	w;
		int		sel;
		logic	chain;
		chain = (n >= CHAIN_START) && (n < CHAIN_START + CHAIN_LEN);
		w = '0;
		if (n == N_INST - 1) begin
			w = {`OP_PAL, 26'h0};		// halt
		end else if (!chain && ((n == ILL_IDX) || (rand_below(64) == 0))) begin
			w = next_rand();
			if (word_kind(w) != K_ILLEGAL)
				w.r.opcode = 6'h3f;		// unused opcode
		end else begin
			sel = rand_below(6);
			w.r.opcode = (sel < 3) ? `OP_INTA : `OP_INTL;
			case (sel)
				0:			w.r.func = `F_ADDQ;
				1:			w.r.func = `F_SUBQ;
				2:			w.r.func = `F_CMPEQ;
				3:			w.r.func = `F_AND;
				4:			w.r.func = `F_BIS;
				default:	w.r.func = `F_XOR;
			endcase
			w.r.ra     = chain ? CHAIN_REG : pick_reg();	// chain reads its own result
			w.r.rb     = pick_reg();
			w.r.sbz    = 3'b0;
			w.r.rc     = chain ? CHAIN_REG : pick_reg();
			w.r.is_lit = (rand_below(2) == 1);
			if (w.r.is_lit)
				w.l.lit = next_rand() >> 24;
		end
		return w;
	endfunction

	// ==================================================
	// drivers act 1 ns after the rising edge
	task automatic apply_reset();
		@(posedge clk);
		#1;
		rst_i      = 1'b1;
		inst_vld_i = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		#1;
		rst_i = 1'b0;
		model_reset();
		@(negedge clk);
		check_status(core_status_o, NO_ERROR);
		check_rdy(inst_rdy_o, 1'b1);
		@(posedge clk);
		#1;
	endtask

	task automatic idle_gap();
		int	gap;
		if (rand_below(4) == 0) begin
			gap = 1 + rand_below(3);
			inst_vld_i = 1'b0;
			repeat (gap) begin
				inst_i = next_rand();		// junk while not valid
				@(posedge clk);
				#1;
			end
		end
	endtask

	// word held until the edge that takes it
	task automatic send_word(inst_u w);
		logic	taken;
		taken      = 1'b0;
		inst_i     = w;
		inst_vld_i = 1'b1;
		while (!taken) begin
			@(negedge clk);
			taken = inst_rdy_o;		// rdy does not look at vld
			@(posedge clk);
			#1;
		end
		model_accept(w);
		inst_vld_i = 1'b0;
	endtask

	task automatic wait_stop();
		@(negedge clk);
		while (core_status_o == NO_ERROR)
			@(negedge clk);
	endtask

	// ==================================================
	// retire monitor
	always @(negedge clk) begin
		if (!rst_i && retire_vld_o)
			check_retire(retire_areg_o, retire_val_o);
	end

	initial begin
		#(WD_CYCLES * CLK_PERIOD);
		$display("run did not finish within %0d cycles", WD_CYCLES);
		$display("test failed");
		$fatal(1, "watchdog expired");
	end

	initial begin
		inst_u	word;
		kind_e	kind;
		inst_vld_i = 1'b0;
		inst_i     = '0;
		rst_i      = 1'b1;
		apply_reset();
		for (int n = 0; n < N_INST; n++) begin
			word = make_word(n);
			kind = word_kind(word);
			if (!((n >= CHAIN_START) && (n < CHAIN_START + CHAIN_LEN)))
				idle_gap();		// chain goes back to back
			send_word(word);
			if (kind != K_OP) begin
				wait_stop();
				check_drained();
				if (kind == K_ILLEGAL) begin
					check_status(core_status_o, HALTED_ON_ILLEGAL);
					apply_reset();		// start over from zeroed state
				end else begin
					check_status(core_status_o, HALTED_ON_HALT);
				end
			end
		end
		// a legal word must stay out once halted
		@(posedge clk);
		#1;
		inst_vld_i = 1'b1;
		inst_i     = {`OP_INTA, 5'd1, 8'h05, 1'b1, `F_ADDQ, 5'd2};
		repeat (20) begin
			@(negedge clk);
			check_rdy(inst_rdy_o, 1'b0);
			check_status(core_status_o, HALTED_ON_HALT);
		end
		$display("test passed");
		$finish;
	end

endmodule
